/* sample_gen_pkg.sv */
`default_nettype none

package sample_gen_pkg;

	localparam int SAMPLE_WIDTH = 16;
	localparam int BATCH_SIZE = 8;
	localparam int BATCH_WIDTH = SAMPLE_WIDTH * BATCH_SIZE;

	// Fibonacci taps for x^16 + x^15 + x^13 + x^4 + 1.
	localparam logic [SAMPLE_WIDTH-1:0] LFSR_TAPS = 16'hd008;

	typedef logic [BATCH_SIZE-1:0][SAMPLE_WIDTH-1:0] batch_t; // Lane 0 is the low sample.

	typedef struct packed {
		logic [BATCH_WIDTH-2*SAMPLE_WIDTH-1:0] pad;
		logic [SAMPLE_WIDTH-1:0] peak;
		logic [SAMPLE_WIDTH-1:0] step;
	} trig_cfg_t;

	// The same payload word is read as lane seeds or as triangle settings.
	typedef union packed {
		batch_t seeds;
		trig_cfg_t trig;
	} cmd_payload_u;

	typedef struct packed {
		cmd_payload_u payload;
		logic halt;
		logic run_rand;
		logic run_trig;
	} ps_cmd_t;

endpackage

`default_nettype wire

/* gen_ctrl_if.sv */
`default_nettype none

interface gen_ctrl_if;
	import sample_gen_pkg::*;

	logic run_rand;
	logic run_trig;
	logic load; // One cycle after a run command was taken.
	logic halt;
	cmd_payload_u payload;

	modport ctrl (
		output run_rand,
		output run_trig,
		output load,
		output halt,
		output payload
	);

	modport src (
		input run_rand,
		input run_trig,
		input load,
		input halt,
		input payload
	);

	modport sel (
		input run_rand,
		input run_trig,
		input load,
		input halt
	);

endinterface

`default_nettype wire

/* lfsr_bank.sv */
`default_nettype none

module lfsr_bank (
	input logic clk,
	input logic rst,
	input logic dac_rdy,
	gen_ctrl_if.src ctl,
	output sample_gen_pkg::batch_t samples
);
	import sample_gen_pkg::*;

	generate
		for (genvar i = 0; i < BATCH_SIZE; i++) begin : g_lane
			logic [SAMPLE_WIDTH-1:0] lane_state;
			logic [SAMPLE_WIDTH-1:0] seed;
			logic feedback;

			assign seed = ctl.payload.seeds[i];
			assign feedback = ^(lane_state & LFSR_TAPS);

			always_ff @(posedge clk) begin
				if (rst || ctl.halt) begin
					lane_state <= SAMPLE_WIDTH'(1);
				end else if (ctl.load) begin
					if (seed == '0) begin
						lane_state <= SAMPLE_WIDTH'(1); // All zeros would lock the register.
					end else begin
						lane_state <= seed;
					end
				end else if (ctl.run_rand && dac_rdy) begin
					lane_state <= {lane_state[SAMPLE_WIDTH-2:0], feedback};
				end
			end

			assign samples[i] = lane_state;

			assert property (@(posedge clk) disable iff (rst)
				ctl.load |=> lane_state != '0);
		end
	endgenerate

endmodule

`default_nettype wire

/* trig_wave_gen.sv */
`default_nettype none

module trig_wave_gen (
	input logic clk,
	input logic rst,
	input logic dac_rdy,
	gen_ctrl_if.src ctl,
	output sample_gen_pkg::batch_t samples
);
	import sample_gen_pkg::*;

	logic [SAMPLE_WIDTH-1:0] level;
	logic down;
	logic [BATCH_SIZE:0][SAMPLE_WIDTH-1:0] lane_level;
	logic [BATCH_SIZE:0] lane_down;
	logic over_peak;

	// Returns {direction, level} of the point after cur.
	function automatic logic [SAMPLE_WIDTH:0] next_point(
		input logic [SAMPLE_WIDTH-1:0] cur,
		input logic cur_down,
		input trig_cfg_t cfg
	);
		logic [SAMPLE_WIDTH:0] sum;
		sum = {1'b0, cur} + {1'b0, cfg.step};
		if (!cur_down) begin
			if (sum >= {1'b0, cfg.peak}) begin
				return {1'b1, cfg.peak};
			end
			return {1'b0, sum[SAMPLE_WIDTH-1:0]};
		end
		if (cur <= cfg.step) begin
			return '0; // Bottom reached, turn up again.
		end
		return {1'b1, cur - cfg.step};
	endfunction

	always_comb begin
		lane_level[0] = level;
		lane_down[0] = down;
		over_peak = 1'b0;
		for (int j = 0; j < BATCH_SIZE; j++) begin
			{lane_down[j+1], lane_level[j+1]} =
				next_point(lane_level[j], lane_down[j], ctl.payload.trig);
			over_peak = over_peak | (lane_level[j] > ctl.payload.trig.peak);
		end
	end

	assign samples = lane_level[BATCH_SIZE-1:0];

	always_ff @(posedge clk) begin
		if (rst || ctl.halt || ctl.load) begin
			level <= '0;
			down <= 1'b0;
		end else if (ctl.run_trig && dac_rdy) begin
			level <= lane_level[BATCH_SIZE]; // Skip ahead a whole batch.
			down <= lane_down[BATCH_SIZE];
		end
	end

	// The level is stale in the load cycle, since the payload changes one edge before it resets.
	assert property (@(posedge clk) disable iff (rst)
		!ctl.load |-> !over_peak);

endmodule

`default_nettype wire

/* sample_cmd_ctrl.sv */
`default_nettype none

module sample_cmd_ctrl #(
	parameter int BS_WIDTH = 16
) (
	input logic clk,
	input logic rst,
	input sample_gen_pkg::ps_cmd_t ps_cmd,
	input logic valid_ps_cmd,
	input logic [BS_WIDTH-1:0] dac_bs,
	input logic valid_dac_batch,
	input logic last_valid,
	gen_ctrl_if.ctrl ctrl
);
	import sample_gen_pkg::*;

	typedef enum logic {IDLE, HALT} state_t;

	state_t state;
	logic [BS_WIDTH-1:0] batch_cnt;
	logic run_rand;
	logic run_trig;
	logic load;
	logic halt_cmd;
	logic halt;
	logic limit_hit;
	logic run_req;
	cmd_payload_u payload;

	assign halt = halt_cmd || state == HALT;
	assign run_req = !ps_cmd.halt && (ps_cmd.run_rand || ps_cmd.run_trig);

	// The delivery that reaches the limit moves the FSM to HALT on this edge.
	assign limit_hit = state == IDLE && dac_bs != '0 && valid_dac_batch &&
		batch_cnt == dac_bs - 1'b1;

	always_ff @(posedge clk) begin
		if (rst || halt) begin
			run_rand <= 1'b0;
			run_trig <= 1'b0;
			load <= 1'b0;
			halt_cmd <= 1'b0;
			payload <= '0;
		end else begin
			load <= 1'b0;
			if (valid_ps_cmd && !limit_hit) begin
				halt_cmd <= ps_cmd.halt;
				run_rand <= ps_cmd.run_rand && !ps_cmd.halt;
				run_trig <= ps_cmd.run_trig && !ps_cmd.halt;
				if (run_req) begin
					payload <= ps_cmd.payload;
					load <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			batch_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (halt_cmd) begin
						state <= HALT;
					end else if (dac_bs != '0 && valid_dac_batch) begin
						batch_cnt <= batch_cnt + 1'b1;
						if (limit_hit) begin
							state <= HALT;
						end
					end
				end
				HALT: begin
					if (!last_valid) begin // Wait for the pipe to drain.
						batch_cnt <= '0;
						state <= IDLE;
					end
				end
			endcase
		end
	end

	assign ctrl.run_rand = run_rand;
	assign ctrl.run_trig = run_trig;
	assign ctrl.load = load;
	assign ctrl.halt = halt;
	assign ctrl.payload = payload;

	assert property (@(posedge clk) disable iff (rst)
		!(load && halt));

	assert property (@(posedge clk) disable iff (rst)
		load |=> !load);

endmodule

`default_nettype wire

/* batch_pipe.sv */
`default_nettype none

module batch_pipe #(
	parameter int DAC_STAGES = 5
) (
	input logic clk,
	input logic rst,
	input logic dac_rdy,
	gen_ctrl_if.sel ctl,
	input sample_gen_pkg::batch_t rand_batch,
	input sample_gen_pkg::batch_t trig_batch,
	output sample_gen_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output logic last_valid
);
	import sample_gen_pkg::*;

	batch_t [DAC_STAGES-1:0] stage_data;
	logic [DAC_STAGES-1:0] stage_valid;
	batch_t in_batch;
	logic in_valid;
	logic out_en;

	assign in_batch = ctl.run_rand ? rand_batch : trig_batch; // Random wins.
	assign in_valid = dac_rdy && (ctl.run_rand || ctl.run_trig) && !ctl.load;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= '0;
		end else if (dac_rdy) begin
			stage_valid <= {stage_valid[DAC_STAGES-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (dac_rdy) begin
			stage_data <= {stage_data[DAC_STAGES-2:0], in_batch};
		end
	end

	assign last_valid = stage_valid[DAC_STAGES-1];
	assign out_en = dac_rdy && !ctl.halt;
	assign dac_batch = out_en ? stage_data[DAC_STAGES-1] : '0;
	assign valid_dac_batch = out_en && last_valid;

	assert property (@(posedge clk) disable iff (rst)
		valid_dac_batch |-> dac_rdy);

endmodule

`default_nettype wire

/* sample_generator.sv */
`default_nettype none

module sample_generator #(
	parameter int BS_WIDTH = 16,
	parameter int DAC_STAGES = 5
) (
	input logic clk,
	input logic rst,
	input logic [sample_gen_pkg::BATCH_WIDTH+2:0] ps_cmd,
	input logic valid_ps_cmd,
	input logic dac_rdy,
	input logic [BS_WIDTH-1:0] dac_bs,
	output logic [sample_gen_pkg::BATCH_WIDTH-1:0] dac_batch,
	output logic valid_dac_batch
);
	import sample_gen_pkg::*;

	batch_t rand_batch;
	batch_t trig_batch;
	logic last_valid;

	gen_ctrl_if u_ctrl_if ();

	sample_cmd_ctrl #(
		.BS_WIDTH(BS_WIDTH)
	) u_cmd_ctrl (
		.clk(clk),
		.rst(rst),
		.ps_cmd(ps_cmd),
		.valid_ps_cmd(valid_ps_cmd),
		.dac_bs(dac_bs),
		.valid_dac_batch(valid_dac_batch),
		.last_valid(last_valid),
		.ctrl(u_ctrl_if.ctrl)
	);

	lfsr_bank u_lfsr_bank (
		.clk(clk),
		.rst(rst),
		.dac_rdy(dac_rdy),
		.ctl(u_ctrl_if.src),
		.samples(rand_batch)
	);

	trig_wave_gen u_trig_wave_gen (
		.clk(clk),
		.rst(rst),
		.dac_rdy(dac_rdy),
		.ctl(u_ctrl_if.src),
		.samples(trig_batch)
	);

	batch_pipe #(
		.DAC_STAGES(DAC_STAGES)
	) u_batch_pipe (
		.clk(clk),
		.rst(rst),
		.dac_rdy(dac_rdy),
		.ctl(u_ctrl_if.sel),
		.rand_batch(rand_batch),
		.trig_batch(trig_batch),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.last_valid(last_valid)
	);

endmodule

`default_nettype wire

/* tb_sample_generator.sv */
`default_nettype none

module tb_sample_generator;
	import sample_gen_pkg::*;

	localparam int BS_WIDTH = 16;
	localparam int TIMEOUT = 2000;
	localparam logic [SAMPLE_WIDTH-1:0] TAP_MASK = 16'hd008; // Bits 15, 14, 12 and 3.
	localparam int MODE_NONE = 0;
	localparam int MODE_RAND = 1;
	localparam int MODE_TRIG = 2;

	logic clk = 1'b0;
	logic rst;
	ps_cmd_t ps_cmd;
	logic valid_ps_cmd;
	logic dac_rdy;
	logic [BS_WIDTH-1:0] dac_bs;
	logic [BATCH_WIDTH-1:0] dac_batch;
	logic valid_dac_batch;

	integer seed = 32'h7923_cc2d;
	int errors = 0;
	int checks = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int delivered = 0;
	int trig_seen = 0;
	int tri_turns = 0;
	bit timed_out = 1'b0;
	bit halt_seen = 1'b0;
	int cur_mode = MODE_NONE; // Run flags the DUT holds in the current cycle.
	int nxt_mode;
	bit cur_load = 1'b0;
	bit nxt_load;
	logic [BS_WIDTH-1:0] bs_val = '0;
	logic [BS_WIDTH-1:0] lim_cnt = '0;
	logic [SAMPLE_WIDTH-1:0] lane [BATCH_SIZE];
	int tri_level;
	int tri_step;
	int tri_peak;
	bit tri_down;
	batch_t exp_q[$];
	int kind_q[$];

	sample_generator #(
		.BS_WIDTH(BS_WIDTH),
		.DAC_STAGES(5)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.ps_cmd(ps_cmd),
		.valid_ps_cmd(valid_ps_cmd),
		.dac_rdy(dac_rdy),
		.dac_bs(dac_bs),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch)
	);

	always #10 clk = ~clk;

	task automatic check_batch(input batch_t got, input batch_t exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_count(input logic [BS_WIDTH-1:0] got, input logic [BS_WIDTH-1:0] exp,
		input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("At %0t: %s", $time, what);
	endtask

	function automatic logic rand_rdy();
		return ($random(seed) & 3) != 0; // High on about three cycles in four.
	endfunction

	function automatic ps_cmd_t rand_cmd(input bit zero_lane);
		ps_cmd_t c;
		c = '0;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			c.payload.seeds[i] = 16'($random(seed));
		end
		if (zero_lane) begin
			c.payload.seeds[$random(seed) & (BATCH_SIZE - 1)] = '0;
		end
		c.run_rand = 1'b1;
		return c;
	endfunction

	function automatic ps_cmd_t trig_cmd(input bit big);
		ps_cmd_t c;
		logic [SAMPLE_WIDTH-1:0] peak;
		c = '0;
		if (big) begin
			peak = 16'h8000 | 16'($random(seed)); // Lets level + step pass 16 bits.
		end else begin
			peak = 16'd200 + (16'($random(seed)) & 16'h0fff);
		end
		c.payload.trig.peak = peak;
		c.payload.trig.step = peak / 16'(3 + ($random(seed) & 7));
		c.run_trig = 1'b1;
		return c;
	endfunction

	task automatic step_triangle();
		if (!tri_down) begin
			if (tri_level + tri_step >= tri_peak) begin
				tri_level = tri_peak;
				tri_down = 1'b1;
				tri_turns++;
			end else begin
				tri_level = tri_level + tri_step;
			end
		end else if (tri_level <= tri_step) begin
			tri_level = 0;
			tri_down = 1'b0;
			tri_turns++;
		end else begin
			tri_level = tri_level - tri_step;
		end
	endtask

	task automatic push_expected();
		batch_t b;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			if (cur_mode == MODE_RAND) begin
				b[i] = lane[i];
				lane[i] = {lane[i][SAMPLE_WIDTH-2:0], ^(lane[i] & TAP_MASK)};
			end else begin
				b[i] = 16'(tri_level);
				step_triangle();
			end
		end
		exp_q.push_back(b);
		kind_q.push_back(cur_mode);
	endtask

	task automatic apply_cmd(input ps_cmd_t cmd);
		if (cmd.halt) begin
			nxt_mode = MODE_NONE;
			halt_seen = 1'b1;
		end else if (cmd.run_rand || cmd.run_trig) begin
			nxt_mode = cmd.run_rand ? MODE_RAND : MODE_TRIG; // Random wins.
			nxt_load = 1'b1;
			for (int i = 0; i < BATCH_SIZE; i++) begin
				lane[i] = (cmd.payload.seeds[i] == '0) ? 16'd1 : cmd.payload.seeds[i];
			end
			tri_level = 0;
			tri_down = 1'b0;
			tri_step = cmd.payload.trig.step;
			tri_peak = cmd.payload.trig.peak;
		end else begin
			nxt_mode = MODE_NONE;
		end
	endtask

	task automatic monitor_output();
		if ($isunknown(valid_dac_batch)) begin
			report_problem("valid_dac_batch is unknown");
		end else if (valid_dac_batch) begin
			delivered++;
			if (exp_q.size() == 0) begin
				report_problem("a valid batch appeared while none was expected");
			end else begin
				if (kind_q.pop_front() == MODE_TRIG) begin
					trig_seen++;
				end
				check_batch(dac_batch, exp_q.pop_front(), "dac_batch");
			end
			if (bs_val != '0) begin
				lim_cnt++;
				if (lim_cnt == bs_val) begin
					halt_seen = 1'b1; // The limit stops generation like a halt.
				end
			end
		end else if (!dac_rdy) begin
			check_batch(dac_batch, '0, "dac_batch"); // The DAC is not ready, so no data shows.
		end
	endtask

	// One clock cycle: drive inputs, let the model follow, then check the output.
	task automatic tick(input logic cmd_valid, input ps_cmd_t cmd, input logic rdy);
		@(posedge clk);
		#2;
		valid_ps_cmd = cmd_valid;
		ps_cmd = cmd;
		dac_rdy = rdy;
		dac_bs = bs_val;
		if (rdy && cur_mode != MODE_NONE && !cur_load) begin
			push_expected();
		end
		nxt_mode = cur_mode;
		nxt_load = 1'b0;
		if (cmd_valid) begin
			apply_cmd(cmd);
		end
		@(negedge clk);
		monitor_output();
		if (halt_seen) begin
			exp_q.delete(); // Batches in flight are gated off.
			kind_q.delete();
			lim_cnt = '0;
			nxt_mode = MODE_NONE;
			nxt_load = 1'b0;
			halt_seen = 1'b0;
		end
		cur_mode = nxt_mode;
		cur_load = nxt_load;
	endtask

	task automatic wait_until(input int target, input bit drain);
		int waited;
		waited = 0;
		while (!timed_out && (drain ? exp_q.size() != 0 : delivered < target)) begin
			tick(1'b0, '0, rand_rdy());
			waited++;
			if (waited == TIMEOUT) begin
				timed_out = 1'b1;
				report_problem("timed out waiting for batches from the DUT");
			end
		end
	endtask

	task automatic stop_and_drain();
		tick(1'b1, '0, rand_rdy());
		wait_until(0, 1'b1);
	endtask

	task automatic end_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	initial begin
		int err_start;
		int limit_start;
		ps_cmd_t c;
		rst = 1'b1;
		valid_ps_cmd = 1'b0;
		ps_cmd = '0;
		dac_rdy = 1'b0;
		dac_bs = '0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		err_start = errors;
		repeat (12) tick(1'b0, '0, 1'b1);
		end_test("reset", err_start);

		err_start = errors;
		tick(1'b1, rand_cmd(1'b1), rand_rdy());
		wait_until(delivered + 24, 1'b0);
		stop_and_drain();
		end_test("random mode", err_start);

		err_start = errors;
		tri_turns = 0;
		tick(1'b1, trig_cmd(1'b0), rand_rdy());
		wait_until(delivered + 16, 1'b0);
		stop_and_drain();
		tick(1'b1, trig_cmd(1'b1), rand_rdy());
		wait_until(delivered + 16, 1'b0);
		stop_and_drain();
		if (tri_turns < 4) begin
			report_problem("the triangle runs did not turn at both peak and zero");
		end
		end_test("triangle mode", err_start);

		err_start = errors;
		bs_val = 16'($unsigned($random(seed)) % 12 + 1);
		limit_start = delivered;
		tick(1'b1, rand_cmd(1'b0), rand_rdy());
		wait_until(delivered + bs_val, 1'b0);
		repeat (200) tick(1'b0, '0, rand_rdy());
		check_count(16'(delivered - limit_start), bs_val, "delivered batch count");
		bs_val = '0;
		end_test("batch limit", err_start);

		err_start = errors;
		tick(1'b1, rand_cmd(1'b0), rand_rdy());
		wait_until(delivered + 6, 1'b0);
		c = '0;
		c.halt = 1'b1;
		c.run_rand = 1'b1; // Halt must override the run flag.
		tick(1'b1, c, rand_rdy());
		repeat (10) tick(1'b0, '0, 1'b1);
		repeat (50) tick(1'b0, '0, rand_rdy());
		tick(1'b1, rand_cmd(1'b1), rand_rdy());
		wait_until(delivered + 10, 1'b0);
		stop_and_drain();
		end_test("halt command", err_start);

		err_start = errors;
		trig_seen = 0;
		tick(1'b1, rand_cmd(1'b0), rand_rdy());
		wait_until(delivered + 4, 1'b0);
		tick(1'b1, trig_cmd(1'b0), rand_rdy());
		wait_until(delivered + 12, 1'b0);
		stop_and_drain();
		if (trig_seen == 0) begin
			report_problem("no triangle batch followed the mode switch");
		end
		end_test("mode switch", err_start);

		$display("Tests: %0d passed, %0d failed. Checks: %0d, errors: %0d.",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sample_generator.f */
sample_gen_pkg.sv
gen_ctrl_if.sv
lfsr_bank.sv
trig_wave_gen.sv
sample_cmd_ctrl.sv
batch_pipe.sv
sample_generator.sv
tb_sample_generator.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DUT and testbench with Verilator, runs the simulation and checks its log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sample_generator

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sample_generator -f sample_generator.f \
	-Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0
